// ==== hdl/rvviPkg.sv ====
// RVFI to RVVI trace adapter shared definitions
// Widths, kept CSR catalogue, interrupt net map and trace structs
`default_nettype none

package rvviPkg;

  ////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////
  typedef logic [31:0] xlenT;
  typedef logic [63:0] orderT;
  typedef logic [4:0]  regAddrT;
  typedef logic [31:0] regMaskT;
  typedef logic [1:0]  modeT;
  typedef logic [11:0] csrAddrT;

  localparam int unsigned NetIdxW = 5;
  typedef logic [NetIdxW-1:0] netIdxT;

  ////////////////////////////////////////////////////////////
  // Kept CSRs
  ////////////////////////////////////////////////////////////
  localparam int unsigned NumCsr = 8;

  // Index into the CSR value and write-back arrays
  typedef enum logic [2:0] {
    CsrMstatus  = 3'd0,
    CsrMie      = 3'd1,
    CsrMtvec    = 3'd2,
    CsrMscratch = 3'd3,
    CsrMepc     = 3'd4,
    CsrMcause   = 3'd5,
    CsrMip      = 3'd6,
    CsrDpc      = 3'd7
  } csrIdxE;

  // Architectural address of each entry, same order as csrIdxE
  localparam csrAddrT CsrAddrTable [NumCsr] = '{
    12'h300, 12'h304, 12'h305, 12'h340,
    12'h341, 12'h342, 12'h344, 12'h7B1
  };

  ////////////////////////////////////////////////////////////
  // Interrupt and debug nets
  ////////////////////////////////////////////////////////////
  localparam int unsigned NumIrqNets = 19;

  // Net index to irq bit: software, timer, external, then local 0..15
  localparam int unsigned IrqNetMap [NumIrqNets] = '{
    3, 7, 11,
    16, 17, 18, 19, 20, 21, 22, 23,
    24, 25, 26, 27, 28, 29, 30, 31
  };

  // Halt request sits just above the irq nets
  localparam netIdxT HaltNetIdx = netIdxT'(19);

  ////////////////////////////////////////////////////////////
  // Trace structs
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic    valid;
    orderT   order;
    xlenT    insn;
    logic    trap;
    logic    intr;
    modeT    mode;
    xlenT    pcRdata;
    regAddrT rdAddr;
    xlenT    rdWdata;
  } retireT;

  typedef struct packed {
    xlenT rdata;
    xlenT wdata;
    xlenT wmask;
  } csrPortT;

  typedef struct packed {
    logic    valid;
    orderT   order;
    xlenT    insn;
    logic    trap;
    logic    intr;
    modeT    mode;
    xlenT    pcRdata;
    regMaskT xWb;
    xlenT    xWdata;
  } traceT;

  typedef struct packed {
    logic   valid;
    netIdxT idx;
    logic   value;
  } netEventT;

endpackage

`default_nettype wire

// ==== hdl/retireCapture.sv ====
// Retirement capture
// Registers one RVFI retirement into an RVVI trace record and
// decodes the single rd write into a one-hot GPR write-back mask
`timescale 1ns/1ps
`default_nettype none

module retireCapture import rvviPkg::*; (
  input  logic   rvvi,
  input  logic   rstN_i,
  input  retireT retire_i,
  output traceT  trace_o
);

  ////////////////////////////////////////////////////////////
  // Write-back decode
  ////////////////////////////////////////////////////////////
  regMaskT wbMaskD;

  // x0 is never written back
  always_comb begin
    wbMaskD = '0;
    if (retire_i.rdAddr != regAddrT'(0)) begin
      wbMaskD = regMaskT'(1) << retire_i.rdAddr;
    end
  end

  ////////////////////////////////////////////////////////////
  // Trace registers
  ////////////////////////////////////////////////////////////
  logic    validQ;
  orderT   orderQ;
  xlenT    insnQ;
  logic    trapQ;
  logic    intrQ;
  modeT    modeQ;
  xlenT    pcQ;
  regMaskT xWbQ;
  xlenT    xWdataQ;

  // Strobe mirrors the input one cycle later
  always_ff @(posedge rvvi or negedge rstN_i) begin
    if (!rstN_i) begin
      validQ <= 1'b0;
    end else begin
      validQ <= retire_i.valid;
    end
  end

  // Fields held until the next retirement
  always_ff @(posedge rvvi) begin
    if (retire_i.valid) begin
      orderQ  <= retire_i.order;
      insnQ   <= retire_i.insn;
      trapQ   <= retire_i.trap;
      intrQ   <= retire_i.intr;
      modeQ   <= retire_i.mode;
      pcQ     <= retire_i.pcRdata;
      xWbQ    <= wbMaskD;
      xWdataQ <= retire_i.rdWdata;
    end
  end

  assign trace_o.valid   = validQ;
  assign trace_o.order   = orderQ;
  assign trace_o.insn    = insnQ;
  assign trace_o.trap    = trapQ;
  assign trace_o.intr    = intrQ;
  assign trace_o.mode    = modeQ;
  assign trace_o.pcRdata = pcQ;
  assign trace_o.xWb     = xWbQ;
  assign trace_o.xWdata  = xWdataQ;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  // One GPR at most, and never x0
  assert property (@(posedge rvvi) disable iff (!rstN_i)
    trace_o.valid |-> ($onehot0(trace_o.xWb) && !trace_o.xWb[0]))
    else $error("retireCapture: xWb not one-hot or zero");

endmodule

`default_nettype wire

// ==== hdl/csrMerge.sv ====
// CSR value reconstruction
// Merges written and read bits per CSR and flags the ones whose
// value changed since the previous retirement
`timescale 1ns/1ps
`default_nettype none

module csrMerge import rvviPkg::*; (
  input  logic              rvvi,
  input  logic              rstN_i,
  input  logic              retValid_i,
  input  csrPortT           csr_i      [NumCsr],
  output xlenT              csrValue_o [NumCsr],
  output logic [NumCsr-1:0] csrWb_o
);

  ////////////////////////////////////////////////////////////
  // Merge
  ////////////////////////////////////////////////////////////
  xlenT mergedD [NumCsr];

  // Written bits under the mask, read bits elsewhere
  always_comb begin
    for (int i = 0; i < NumCsr; i++) begin
      mergedD[i] = (csr_i[i].wdata & csr_i[i].wmask)
                 | (csr_i[i].rdata & ~csr_i[i].wmask);
    end
  end

  ////////////////////////////////////////////////////////////
  // Last reported values and write-back flags
  ////////////////////////////////////////////////////////////
  xlenT              valueQ [NumCsr];
  logic [NumCsr-1:0] wbQ;

  always_ff @(posedge rvvi or negedge rstN_i) begin
    if (!rstN_i) begin
      wbQ <= '0;
      for (int i = 0; i < NumCsr; i++) begin
        valueQ[i] <= '0;
      end
    end else begin
      // Flags only live for the cycle after a strobe
      wbQ <= '0;
      if (retValid_i) begin
        for (int i = 0; i < NumCsr; i++) begin
          wbQ[i]    <= (mergedD[i] != valueQ[i]);
          valueQ[i] <= mergedD[i];
        end
      end
    end
  end

  assign csrValue_o = valueQ;
  assign csrWb_o    = wbQ;

endmodule

`default_nettype wire

// ==== hdl/netWatch.sv ====
// Net level-change watcher
// Samples a group of nets, marks each change pending and offers the
// lowest pending net until it is granted
`timescale 1ns/1ps
`default_nettype none

module netWatch import rvviPkg::*; #(
  parameter int unsigned NumNets = 1
) (
  input  logic               rvvi,
  input  logic               rstN_i,
  input  logic [NumNets-1:0] nets_i,
  input  logic               grant_i,
  output logic               req_o,
  output netIdxT             idx_o,
  output logic               value_o
);

  ////////////////////////////////////////////////////////////
  // Level and pending state
  ////////////////////////////////////////////////////////////
  logic [NumNets-1:0] levelQ;
  logic [NumNets-1:0] pendQ;
  logic [NumNets-1:0] changedD;
  logic [NumNets-1:0] clearD;

  // Any difference against the last sample is a change
  assign changedD = nets_i ^ levelQ;

  ////////////////////////////////////////////////////////////
  // Lowest pending net
  ////////////////////////////////////////////////////////////
  netIdxT lowIdxD;
  logic   lowValueD;

  always_comb begin
    lowIdxD   = '0;
    lowValueD = 1'b0;
    // Walk down so the lowest index wins
    for (int i = NumNets - 1; i >= 0; i--) begin
      if (pendQ[i]) begin
        lowIdxD   = netIdxT'(i);
        lowValueD = levelQ[i];
      end
    end
  end

  // Granted net drops out, unless it moved again this cycle
  always_comb begin
    clearD = '0;
    for (int i = 0; i < NumNets; i++) begin
      clearD[i] = grant_i && (lowIdxD == netIdxT'(i)) && !changedD[i];
    end
  end

  always_ff @(posedge rvvi or negedge rstN_i) begin
    if (!rstN_i) begin
      levelQ <= '0;
      pendQ  <= '0;
    end else begin
      levelQ <= nets_i;
      pendQ  <= (pendQ & ~clearD) | changedD;
    end
  end

  assign req_o   = |pendQ;
  assign idx_o   = lowIdxD;
  // Last sampled level of the offered net
  assign value_o = lowValueD;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  // Arbiter only grants a live request
  assert property (@(posedge rvvi) disable iff (!rstN_i)
    grant_i |-> req_o)
    else $error("netWatch: grant without request");

endmodule

`default_nettype wire

// ==== hdl/netArbiter.sv ====
// Net event arbiter
// Fixed priority between the halt and irq watchers, halt first,
// and registers the winner onto the single net-event port
`timescale 1ns/1ps
`default_nettype none

module netArbiter import rvviPkg::*; (
  input  logic     rvvi,
  input  logic     rstN_i,
  input  logic     haltReq_i,
  input  logic     haltValue_i,
  input  logic     irqReq_i,
  input  netIdxT   irqIdx_i,
  input  logic     irqValue_i,
  output logic     haltGrant_o,
  output logic     irqGrant_o,
  output netEventT event_o
);

  ////////////////////////////////////////////////////////////
  // Grant
  ////////////////////////////////////////////////////////////
  assign haltGrant_o = haltReq_i;
  assign irqGrant_o  = irqReq_i && !haltReq_i;

  ////////////////////////////////////////////////////////////
  // Event register
  ////////////////////////////////////////////////////////////
  logic   validQ;
  netIdxT idxQ;
  logic   valueQ;

  // One event per cycle at most
  always_ff @(posedge rvvi or negedge rstN_i) begin
    if (!rstN_i) begin
      validQ <= 1'b0;
    end else begin
      validQ <= haltGrant_o || irqGrant_o;
    end
  end

  always_ff @(posedge rvvi) begin
    if (haltGrant_o) begin
      idxQ   <= HaltNetIdx;
      valueQ <= haltValue_i;
    end else if (irqGrant_o) begin
      idxQ   <= irqIdx_i;
      valueQ <= irqValue_i;
    end
  end

  assign event_o.valid = validQ;
  assign event_o.idx   = idxQ;
  assign event_o.value = valueQ;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  assert property (@(posedge rvvi) disable iff (!rstN_i)
    !(haltGrant_o && irqGrant_o))
    else $error("netArbiter: both watchers granted");

endmodule

`default_nettype wire

// ==== hdl/rvfiToRvvi.sv ====
// RVFI to RVVI trace adapter top level
// Retirement capture and CSR merge side by side, plus two net
// watchers sharing one event port through a fixed-priority arbiter
`timescale 1ns/1ps
`default_nettype none

module rvfiToRvvi import rvviPkg::*; #(
  parameter int unsigned IrqNets  = NumIrqNets,
  parameter int unsigned HaltNets = 1
) (
  input  logic              rvvi,
  input  logic              rstN_i,
  input  retireT            retire_i,
  input  csrPortT           csr_i      [NumCsr],
  input  logic [31:0]       irq_i,
  input  logic              haltReq_i,
  output traceT             trace_o,
  output xlenT              csrValue_o [NumCsr],
  output logic [NumCsr-1:0] csrWb_o,
  output netEventT          netEvent_o
);

  ////////////////////////////////////////////////////////////
  // Retirement path
  ////////////////////////////////////////////////////////////
  retireCapture u_retireCapture (
    .rvvi      (rvvi),
    .rstN_i    (rstN_i),
    .retire_i  (retire_i),
    .trace_o   (trace_o)
  );

  // Same strobe as the trace record
  csrMerge u_csrMerge (
    .rvvi       (rvvi),
    .rstN_i     (rstN_i),
    .retValid_i (retire_i.valid),
    .csr_i      (csr_i),
    .csrValue_o (csrValue_o),
    .csrWb_o    (csrWb_o)
  );

  ////////////////////////////////////////////////////////////
  // Net path
  ////////////////////////////////////////////////////////////
  logic [IrqNets-1:0]  irqNets;
  logic [HaltNets-1:0] haltNets;
  logic                irqReq;
  netIdxT              irqIdx;
  logic                irqValue;
  logic                irqGrant;
  logic                haltReq;
  logic                haltValue;
  logic                haltGrant;

  // Architectural irq lines only
  for (genvar g = 0; g < IrqNets; g++) begin : gIrqSel
    assign irqNets[g] = irq_i[IrqNetMap[g]];
  end

  assign haltNets = HaltNets'(haltReq_i);

  netWatch #(.NumNets(IrqNets)) u_irqWatch (
    .rvvi    (rvvi),
    .rstN_i  (rstN_i),
    .nets_i  (irqNets),
    .grant_i (irqGrant),
    .req_o   (irqReq),
    .idx_o   (irqIdx),
    .value_o (irqValue)
  );

  // Single net, index is replaced by the arbiter
  netWatch #(.NumNets(HaltNets)) u_haltWatch (
    .rvvi    (rvvi),
    .rstN_i  (rstN_i),
    .nets_i  (haltNets),
    .grant_i (haltGrant),
    .req_o   (haltReq),
    .idx_o   (),
    .value_o (haltValue)
  );

  netArbiter u_netArbiter (
    .rvvi        (rvvi),
    .rstN_i      (rstN_i),
    .haltReq_i   (haltReq),
    .haltValue_i (haltValue),
    .irqReq_i    (irqReq),
    .irqIdx_i    (irqIdx),
    .irqValue_i  (irqValue),
    .haltGrant_o (haltGrant),
    .irqGrant_o  (irqGrant),
    .event_o     (netEvent_o)
  );

endmodule

`default_nettype wire

// ==== dv/tbClock.sv ====
// Testbench clock and reset generator
// Free-running clock and an active-low reset held for a set number of cycles
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int unsigned PeriodNs    = 10,
  parameter int unsigned ResetCycles = 4
) (
  output logic rvvi_o,
  output logic rstN_o
);

  initial begin
    rvvi_o = 1'b0;
    forever #(PeriodNs / 2) rvvi_o = ~rvvi_o;
  end

  // Release just after an edge so no flop sees it mid-edge
  initial begin
    rstN_o = 1'b0;
    repeat (ResetCycles) @(posedge rvvi_o);
    #1;
    rstN_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== dv/tbTop.sv ====
// Testbench for the RVFI to RVVI trace adapter
// Random retirements, CSR traffic and net toggles, checked at each
// falling edge against a cycle model built from the adapter's rules
`timescale 1ns/1ps
`default_nettype none

module tbTop import rvviPkg::*; ();

  localparam int unsigned PeriodNs     = 10;
  localparam int unsigned RunCycles    = 2000;
  localparam int unsigned MarginCycles = 300;
  localparam int unsigned RandomCycles = 1900;

  logic              rvvi;
  logic              rstN;
  retireT            retire;
  csrPortT           csr [NumCsr];
  logic [31:0]       irq;
  logic              haltReq;
  traceT             trace;
  xlenT              csrValue [NumCsr];
  logic [NumCsr-1:0] csrWb;
  netEventT          netEvent;

  // Model state, nets 0..18 are irq lines and net 19 is the halt request
  logic              expTraceValid;
  retireT            expRetire;
  logic [NumCsr-1:0] expCsrWb;
  xlenT              lastCsr [NumCsr];
  logic [19:0]       netLevel;
  logic [19:0]       netPend;
  logic              expEvValid;
  logic [4:0]        expEvIdx;
  logic              expEvValue;
  orderT             nextOrder;

  tbClock #(.PeriodNs(PeriodNs), .ResetCycles(4)) u_clock (
    .rvvi_o (rvvi),
    .rstN_o (rstN)
  );

  rvfiToRvvi #(.IrqNets(19), .HaltNets(1)) u_dut (
    .rvvi       (rvvi),
    .rstN_i     (rstN),
    .retire_i   (retire),
    .csr_i      (csr),
    .irq_i      (irq),
    .haltReq_i  (haltReq),
    .trace_o    (trace),
    .csrValue_o (csrValue),
    .csrWb_o    (csrWb),
    .netEvent_o (netEvent)
  );

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////
  // Software, timer and external first, then local 0..15 on bits 16..31
  function automatic logic [4:0] irqBitOf(int unsigned net);
    case (net)
      0: return 5'd3;
      1: return 5'd7;
      2: return 5'd11;
      default: return 5'(net + 13);
    endcase
  endfunction

  function automatic logic [19:0] netsNow(logic [31:0] irqVec, logic halt);
    logic [19:0] nets;
    for (int i = 0; i < 19; i++) begin
      nets[i] = irqVec[irqBitOf(i)];
    end
    nets[19] = halt;
    return nets;
  endfunction

  // Halt wins, then the lowest irq net
  function automatic int pickNet(logic [19:0] pend);
    if (pend[19]) return 19;
    for (int i = 0; i < 19; i++) begin
      if (pend[i]) return i;
    end
    return -1;
  endfunction

  function automatic regMaskT oneHotOf(regAddrT addr);
    if (addr == 5'd0) return '0;
    return 32'h1 << addr;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////
  task automatic failWith(string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "run stopped");
  endtask

  task automatic checkValue(string name, logic [63:0] expected, logic [63:0] actual);
    assert (actual === expected)
      else failWith($sformatf("FAIL at %0t: %s expected 0x%0h actual 0x%0h",
                              $time, name, expected, actual));
  endtask

  task automatic checkOutputs();
    checkValue("trace_o.valid", 64'(expTraceValid), 64'(trace.valid));
    if (expTraceValid) begin
      checkValue("trace_o.order", 64'(expRetire.order), 64'(trace.order));
      checkValue("trace_o.insn", 64'(expRetire.insn), 64'(trace.insn));
      checkValue("trace_o.pcRdata", 64'(expRetire.pcRdata), 64'(trace.pcRdata));
      checkValue("trace_o.trap", 64'(expRetire.trap), 64'(trace.trap));
      checkValue("trace_o.intr", 64'(expRetire.intr), 64'(trace.intr));
      checkValue("trace_o.mode", 64'(expRetire.mode), 64'(trace.mode));
      checkValue("trace_o.xWb", 64'(oneHotOf(expRetire.rdAddr)), 64'(trace.xWb));
      checkValue("trace_o.xWdata", 64'(expRetire.rdWdata), 64'(trace.xWdata));
    end
    checkValue("csrWb_o", 64'(expCsrWb), 64'(csrWb));
    for (int i = 0; i < NumCsr; i++) begin
      checkValue($sformatf("csrValue_o[%0d]", i), 64'(lastCsr[i]), 64'(csrValue[i]));
    end
    checkValue("netEvent_o.valid", 64'(expEvValid), 64'(netEvent.valid));
    if (expEvValid) begin
      checkValue("netEvent_o.idx", 64'(expEvIdx), 64'(netEvent.idx));
      checkValue("netEvent_o.value", 64'(expEvValue), 64'(netEvent.value));
    end
  endtask

  // Inputs seen now are what the next rising edge samples
  task automatic advanceModel();
    xlenT        merged;
    logic [19:0] nowNets;
    logic [19:0] changed;
    int          pick;
    expTraceValid = retire.valid;
    if (retire.valid) expRetire = retire;
    expCsrWb = '0;
    if (retire.valid) begin
      for (int i = 0; i < NumCsr; i++) begin
        // Each bit comes from the write where masked, else from the read
        for (int b = 0; b < 32; b++) begin
          merged[b] = csr[i].wmask[b] ? csr[i].wdata[b] : csr[i].rdata[b];
        end
        expCsrWb[i] = (merged != lastCsr[i]);
        lastCsr[i]  = merged;
      end
    end
    // Granted net is reported with its last sampled level
    pick       = pickNet(netPend);
    expEvValid = (pick >= 0);
    if (expEvValid) begin
      expEvIdx   = 5'(pick);
      expEvValue = netLevel[5'(pick)];
    end
    nowNets = netsNow(irq, haltReq);
    changed = nowNets ^ netLevel;
    // A net that moves again in its grant cycle stays pending
    if (expEvValid && !changed[5'(pick)]) netPend[5'(pick)] = 1'b0;
    netPend  = netPend | changed;
    netLevel = nowNets;
  endtask

  task automatic resetModel();
    expTraceValid = 1'b0;
    expCsrWb      = '0;
    netLevel      = '0;
    netPend       = '0;
    expEvValid    = 1'b0;
    for (int i = 0; i < NumCsr; i++) begin
      lastCsr[i] = '0;
    end
  endtask

  // Outputs settle after the rising edge, so compare at the falling one
  always @(negedge rvvi) begin
    if (!rstN) begin
      resetModel();
      checkValue("trace_o.valid", 64'(0), 64'(trace.valid));
      checkValue("csrWb_o", 64'(0), 64'(csrWb));
      checkValue("netEvent_o.valid", 64'(0), 64'(netEvent.valid));
    end else begin
      checkOutputs();
      advanceModel();
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  task automatic driveRandom();
    retire.valid = 1'($urandom_range(0, 1));
    if (retire.valid) begin
      retire.order = nextOrder;
      nextOrder    = nextOrder + 64'd1;
    end
    retire.insn    = $urandom();
    retire.pcRdata = $urandom();
    retire.trap    = 1'($urandom());
    retire.intr    = 1'($urandom());
    retire.mode    = 2'($urandom());
    retire.rdAddr  = ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom());
    retire.rdWdata = $urandom();
    // Half the CSRs keep their reported value so some flags stay low
    for (int i = 0; i < NumCsr; i++) begin
      csr[i].wdata = $urandom();
      if ($urandom_range(0, 1) == 0) begin
        csr[i].rdata = lastCsr[i];
        csr[i].wmask = '0;
      end else begin
        csr[i].rdata = $urandom();
        csr[i].wmask = $urandom() & $urandom();
      end
    end
    // Sparse toggles, unmapped irq bits included
    if ($urandom_range(0, 7) == 0) irq = irq ^ (32'h1 << $urandom_range(0, 31));
    if ($urandom_range(0, 15) == 0) haltReq = ~haltReq;
  endtask

  initial begin
    void'($urandom(88));
    retire    = '0;
    irq       = '0;
    haltReq   = 1'b0;
    nextOrder = '0;
    for (int i = 0; i < NumCsr; i++) begin
      csr[i] = '0;
    end
    @(posedge rstN);
    repeat (RandomCycles) begin
      @(posedge rvvi);
      #1;
      driveRandom();
    end
    // Halt and irq nets move together
    @(posedge rvvi);
    #1;
    retire.valid = 1'b0;
    haltReq      = ~haltReq;
    irq[3]       = ~irq[3];
    irq[16]      = ~irq[16];
    // Drain every pending net change, the watchdog bounds the wait
    @(posedge rvvi);
    while (netPend != '0) begin
      @(posedge rvvi);
    end
    // Last event shows one cycle after its grant
    repeat (2) @(posedge rvvi);
    $display("All tests passed!");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (RunCycles + MarginCycles) @(posedge rvvi);
    failWith($sformatf("Timeout: run did not finish within %0d cycles",
                       RunCycles + MarginCycles));
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/rvviPkg.sv
hdl/retireCapture.sv
hdl/csrMerge.sv
hdl/netWatch.sv
hdl/netArbiter.sv
hdl/rvfiToRvvi.sv
dv/tbClock.sv
dv/tbTop.sv

// ==== Makefile ====
# Verilator build and run for the RVFI to RVVI trace adapter

VERILATOR  ?= verilator
TOP        := tbTop
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
